//--- femtoCore.f
hw/rvPkg.sv
hw/rvDecoder.sv
hw/rvRegFile.sv
hw/rvAlu.sv
hw/rvLoadStore.sv
hw/femtoCore.sv
bench/femtoMemModel.sv
bench/femtoCoreTb.sv

//--- build.sh
#!/bin/sh
# Compile the femtoCore testbench with Verilator and run it
# The exit status of the simulation is the result of the run
set -e
cd "$(dirname "$0")"
verilator --binary --timing -j 0 --top-module femtoCoreTb -f femtoCore.f -o femtoSim
./obj_dir/femtoSim

//--- bench/femtoCoreTb.sv
// Testbench for the femtoCore RV32I core
// Program assembly with expected bus writes derived from RV32I rules
// Clock, reset, random busy stretching, watchdog and bus assertions
`default_nettype none

module femtoCoreTb;
   timeunit 1ns;
   timeprecision 100ps;
   import rvPkg::*;

   localparam int    clkPeriod  = 40;
   localparam int    memWords   = 1024;
   localparam word_t resultBase = 32'h0000_0800;  // Result area, x10
   localparam word_t poison     = 32'hbad0_c0de;  // Stored only on wrong paths, x7
   localparam word_t marker     = 32'h600d_0001;  // Right-path marker, x5

   typedef struct packed {
      word_t      addr;
      word_t      data;
      logic [3:0] mask;
   } busWrite_s;

   logic       clk        = 1'b0;
   logic       reset;
   logic       loadImage;
   logic [1:0] busyLength = 2'd0;
   memReq_s    memReq;
   memRsp_s    memRsp;
   word_t      image [memWords];
   busWrite_s  expected [$];      // Bus writes in program order
   word_t      lcgState   = 32'hd362_9f89;
   int         pc         = 0;    // Assembly address
   int         slot       = 0;    // Next result word
   int         progWords  = 0;
   int         edgeCount  = 0;
   logic       done       = 1'b0;
   logic       fetchSeen  = 1'b0;

   femtoCore femtoCore_i (.clk(clk), .reset(reset), .memReq(memReq), .memRsp(memRsp));

   femtoMemModel memModel_i (
      .clk(clk), .memReq(memReq), .memRsp(memRsp),
      .busyLength(busyLength), .loadImage(loadImage), .image(image)
   );

   always #(clkPeriod/2) clk = ~clk;

   function automatic word_t lcg();
      lcgState = lcgState * 32'd1664525 + 32'd1013904223;
      return lcgState;
   endfunction

   // RV32I encodings
   function automatic word_t encR(int f7, int rs2, int rs1, int f3, int rd);
      return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'h33};
   endfunction
   function automatic word_t encI(int imm, int rs1, int f3, int rd, int op);
      return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op[6:0]};
   endfunction
   function automatic word_t encS(int imm, int rs2, int rs1, int f3);
      return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], 7'h23};
   endfunction
   function automatic word_t encB(int imm, int rs2, int rs1, int f3);
      return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], 7'h63};
   endfunction
   function automatic word_t encU(int imm20, int rd, int op);
      return {imm20[19:0], rd[4:0], op[6:0]};
   endfunction
   function automatic word_t encJ(int imm, int rd);
      return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'h6f};
   endfunction

   // Reference results
   function automatic word_t aluRule(int f3, int alt, word_t a, word_t b);
      case (f3)
         0:       return (alt != 0) ? a - b : a + b;
         1:       return a << b[4:0];
         2:       return {31'b0, $signed(a) < $signed(b)};
         3:       return {31'b0, a < b};
         4:       return a ^ b;
         5:       return (alt != 0) ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
         6:       return a | b;
         default: return a & b;
      endcase
   endfunction

   function automatic logic branchRule(int f3, word_t a, word_t b);
      case (f3)
         0:       return a == b;
         1:       return a != b;
         4:       return $signed(a) < $signed(b);
         5:       return $signed(a) >= $signed(b);
         6:       return a < b;
         default: return a >= b;
      endcase
   endfunction

   function automatic word_t extendLoad(word_t w, int off, int f3);
      word_t s;
      s = w >> (8 * off);
      case (f3)
         0:       return {{24{s[7]}}, s[7:0]};   // LB
         4:       return {24'b0, s[7:0]};        // LBU
         1:       return {{16{s[15]}}, s[15:0]}; // LH
         5:       return {16'b0, s[15:0]};
         default: return s;
      endcase
   endfunction

   function automatic word_t laneMask(logic [3:0] m);
      return {{8{m[3]}}, {8{m[2]}}, {8{m[1]}}, {8{m[0]}}};
   endfunction

   task automatic emit(word_t w);
      image[pc / 4] = w;
      pc += 4;
   endtask

   task automatic expectWrite(word_t addr, logic [3:0] mask, word_t data);
      expected.push_back({addr, data, mask});
   endtask

   task automatic storeResult(int rs, word_t value);  // SW rs to the next slot
      emit(encS(slot * 4, rs, 10, 2));
      expectWrite(resultBase + slot * 4, 4'hf, value);
      slot++;
   endtask

   task automatic loadConst(int rd, word_t v);  // LUI + ADDI
      word_t hi;
      hi = (v + 32'h800) >> 12;
      emit(encU(hi, rd, 'h37));
      emit(encI(v, rd, 0, rd, 'h13));
   endtask

   task automatic assemble();
      word_t a;
      word_t b;
      word_t t;
      word_t v;
      int    f3;
      int    alt;
      int    base;
      int    loadKinds [5];
      for (int k = 0; k < memWords; k++) begin
         image[k] = word_t'(k) ^ 32'h5a5a_0000;  // Fill, distinct per word
      end
      loadConst(10, resultBase);
      loadConst(5, marker);
      loadConst(7, poison);
      for (int op = 0; op < 10; op++) begin  // 8 is SUB, 9 is SRA
         f3  = (op < 8) ? op : ((op == 8) ? 0 : 5);
         alt = (op >= 8) ? 1 : 0;
         a = lcg();
         b = lcg();
         loadConst(1, a);
         loadConst(2, b);
         emit(encR(alt * 32, 2, 1, f3, 3));
         storeResult(3, aluRule(f3, alt, a, b));
         if (op != 8) begin  // No SUBI
            a = lcg();
            t = lcg();
            b = (f3 == 1 || f3 == 5) ? {27'b0, t[4:0]} : {{20{t[11]}}, t[11:0]};
            loadConst(1, a);
            v = (f3 == 1 || f3 == 5) ? {20'b0, 1'b0, alt[0], 5'b0, t[4:0]} : b;  // imm[10] is SRAI
            emit(encI(v, 1, f3, 3, 'h13));
            storeResult(3, aluRule(f3, alt, a, b));
         end
      end
      v = lcg() >> 12;  // LUI
      emit(encU(v, 3, 'h37));
      storeResult(3, v << 12);
      v = lcg() >> 12;  // AUIPC, target padded above addrWidth
      t = (pc + (v << 12)) & 32'h00ff_ffff;
      emit(encU(v, 3, 'h17));
      storeResult(3, t);
      v = lcg();  // Byte and halfword stores at each offset
      loadConst(2, v);
      for (int off = 0; off < 4; off++) begin
         emit(encS(slot * 4 + off, 2, 10, 0));
         expectWrite(resultBase + slot * 4 + off, 4'b0001 << off, {24'b0, v[7:0]} << (8 * off));
         slot++;
      end
      for (int off = 0; off < 4; off += 2) begin
         emit(encS(slot * 4 + off, 2, 10, 1));
         expectWrite(resultBase + slot * 4 + off, 4'b0011 << off, {16'b0, v[15:0]} << (8 * off));
         slot++;
      end
      v = 32'h7f80_81f2;  // Both sign cases in bytes and halves
      loadConst(2, v);
      base = slot * 4;
      storeResult(2, v);
      loadKinds = '{0, 4, 1, 5, 2};
      for (int k = 0; k < 5; k++) begin
         f3 = loadKinds[k];
         for (int off = 0; off < 4; off += ((f3 % 4 == 0) ? 1 : ((f3 % 4 == 1) ? 2 : 4))) begin
            emit(encI(base + off, 10, f3, 3, 'h03));
            storeResult(3, extendLoad(v, off, f3));
         end
      end
      a = lcg();
      b = lcg();
      b[31] = ~a[31];  // Signed and unsigned order differ
      for (int p = 0; p < 3; p++) begin  // (a,b), (b,a), (a,a)
         loadConst(1, (p == 1) ? b : a);
         loadConst(2, (p == 0) ? b : a);
         for (int c = 0; c < 6; c++) begin
            f3 = (c < 2) ? c : c + 2;
            base = slot * 4;
            if (branchRule(f3, (p == 1) ? b : a, (p == 0) ? b : a)) begin
               emit(encB(8, 2, 1, f3));      // Skips the poison store
               emit(encS(base, 7, 10, 2));
               storeResult(5, marker);
            end else begin
               emit(encB(12, 2, 1, f3));     // Target is the poison store
               storeResult(5, marker);
               emit(encJ(8, 0));
               emit(encS(base, 7, 10, 2));
            end
         end
      end
      t = pc + 4;  // JAL link
      emit(encJ(8, 3));
      emit(encS(slot * 4, 7, 10, 2));
      storeResult(3, t);
      t = pc;      // JALR to odd address, LSB cleared
      emit(encU(0, 1, 'h17));
      emit(encI(13, 1, 0, 3, 'h67));
      emit(encS(slot * 4, 7, 10, 2));
      storeResult(3, t + 8);
      storeResult(5, marker);  // Last write ends the run
      emit(encJ(0, 0));
      progWords = pc / 4;
   endtask

   task automatic abortRun(string why);
      $display("%s", why);
      $display("tests failed");
      $fatal(1);
   endtask

   task automatic mismatch(string name, word_t exp, word_t act);
      $display("MISMATCH at %0t ns: %s expected %h actual %h", $time, name, exp, act);
      abortRun("bus value differs from the reference result");
   endtask

   always @(posedge clk) begin : stretchBusy
      word_t r;
      #1;
      r = lcg();
      busyLength = r[31:30];  // 0 to 3 cycles
   end

   always @(posedge clk) begin
      edgeCount <= edgeCount + 1;
      if (!reset && edgeCount > 0) begin
         assert (!memReq.rstrb && memReq.wmask == 4'b0)
            else abortRun("memory request issued while reset is low");
      end
   end

   always @(posedge clk) begin
      if (reset && memReq.rstrb && !fetchSeen) begin
         fetchSeen <= 1'b1;
         assert (memReq.addr == {8'b0, resetAddr})
            else mismatch("memReq.addr", {8'b0, resetAddr}, memReq.addr);
      end
   end

   always @(posedge clk) begin
      if (reset && (memRsp.rbusy || memRsp.wbusy)) begin
         assert (!memReq.rstrb && memReq.wmask == 4'b0)
            else abortRun("request issued while the memory is busy");
      end
   end

   always @(posedge clk) begin
      if (reset && memReq.wmask != 4'b0) begin
         assert (memReq.wdata != poison)
            else abortRun("poison value written, a wrong path was executed");
      end
   end

   always @(posedge clk) begin : checkWrite
      busWrite_s e;
      word_t     m;
      logic      ok;
      if (reset && memReq.wmask != 4'b0) begin
         if (expected.size() == 0) begin
            abortRun("bus write after the last expected result");
         end else begin
            e  = expected.pop_front();
            m  = laneMask(e.mask);
            ok = memReq.addr == e.addr && memReq.wmask == e.mask &&
                 (memReq.wdata & m) == (e.data & m);
            if (ok && expected.size() == 0) begin
               done <= 1'b1;
            end
            assert (ok) else begin
               if (memReq.addr != e.addr) begin
                  mismatch("memReq.addr", e.addr, memReq.addr);
               end else if (memReq.wmask != e.mask) begin
                  mismatch("memReq.wmask", {28'b0, e.mask}, {28'b0, memReq.wmask});
               end else begin
                  mismatch("memReq.wdata", e.data & m, memReq.wdata & m);
               end
            end
         end
      end
   end

   initial begin
      wait (progWords != 0);
      #(clkPeriod * (20 * progWords + 100));  // 20 cycles per instruction plus margin
      abortRun("watchdog expired before the program finished");
   end

   initial begin
      reset     = 1'b0;
      loadImage = 1'b1;
      assemble();
      @(posedge clk);
      #1 loadImage = 1'b0;
      repeat (4) @(posedge clk);
      #1 reset = 1'b1;  // Released after 5 edges
      wait (done);
      $display("all tests passed");
      $finish;
   end

endmodule

`default_nettype wire

//--- bench/femtoMemModel.sv
// Memory model for the femtoCore bus
// Word-addressed array with byte-masked writes and latched read data
// Read and write busy stretched by a per-cycle length from the testbench
`default_nettype none

module femtoMemModel (
   input  logic           clk,
   input  rvPkg::memReq_s memReq,
   output rvPkg::memRsp_s memRsp,
   input  logic [1:0]     busyLength,  // Busy cycles for a request taken now
   input  logic           loadImage,   // Copies image into the array
   input  rvPkg::word_t   image [1024]
);
   timeunit 1ns;
   timeprecision 100ps;
   import rvPkg::*;

   localparam int memWords = 1024;

   word_t      mem [memWords];
   memReq_s    req;
   logic [1:0] stretch;
   logic       loadNow;
   logic [1:0] readLeft  = 2'd0;   // Cycles of rbusy still to come
   logic [1:0] writeLeft = 2'd0;
   word_t      readWord  = '0;

   assign memRsp = {readWord, readLeft != 2'd0, writeLeft != 2'd0};

   always @(posedge clk) begin
      req     = memReq;      // Sampled at the edge
      stretch = busyLength;
      loadNow = loadImage;
      #1;
      if (loadNow) begin
         for (int k = 0; k < memWords; k++) begin
            mem[k] = image[k];
         end
      end
      if (req.rstrb) begin
         readWord = mem[req.addr[11:2]];  // Held until the next read
         readLeft = stretch;
      end else if (readLeft != 2'd0) begin
         readLeft = readLeft - 2'd1;
      end
      if (req.wmask != 4'b0) begin
         for (int b = 0; b < 4; b++) begin
            if (req.wmask[b]) begin
               mem[req.addr[11:2]][8*b +: 8] = req.wdata[8*b +: 8];  // Masked lanes only
            end
         end
         writeLeft = stretch;
      end else if (writeLeft != 2'd0) begin
         writeLeft = writeLeft - 2'd1;
      end
   end

endmodule

`default_nettype wire

//--- hw/femtoCore.sv
// Multi-cycle RV32I core, top level
// One-hot fetch/execute sequencer with program counter
// PC+imm, JALR and load/store address adders, next-PC choice
// Write-back mux and memory bus drive
// Instances of decoder, register file, ALU and load/store alignment
`default_nettype none

module femtoCore (
   input  logic           clk,
   input  logic           reset,     // Active low
   output rvPkg::memReq_s memReq,
   input  rvPkg::memRsp_s memRsp
);
   import rvPkg::*;

   logic [stateCount-1:0] state;      // One-hot
   addr_t      pc;
   addr_t      pcPlus4;
   addr_t      pcPlusImm;   // Branch, JAL and AUIPC target
   addr_t      rs1PlusImm;  // JALR target
   addr_t      lsAddr;      // Load/store address
   addr_t      pcImm;
   addr_t      lsImm;

   decoded_s   dec;
   logic [4:0] rs1Id;
   logic [4:0] rs2Id;
   word_t      rs1;
   word_t      rs2;
   logic       instrReady;  // Instruction word valid on rdata
   logic       isAlu;
   logic       aluStart;
   word_t      aluIn2;
   word_t      aluResult;
   logic       predicate;
   word_t      loadData;
   word_t      storeWdata;
   logic [3:0] storeMask;
   logic       writeBack;
   word_t      writeBackData;
   logic       jumpToPcImm;
   logic       memAccess;
   logic       fetchPhase;

   assign instrReady  = state[waitInstrBit] & !memRsp.rbusy;
   assign isAlu       = dec.isAluImm | dec.isAluReg;
   assign aluStart    = state[execute1Bit] & isAlu;
   assign aluIn2      = dec.aluCtrl.useImm ? dec.iImm : rs2;
   assign jumpToPcImm = dec.isJal | (dec.isBranch & predicate);
   assign memAccess   = dec.isLoad | dec.isStore;
   assign fetchPhase  = state[fetchBit] | state[waitInstrBit];

   rvDecoder decoder_i (
      .clk       (clk),
      .load      (instrReady),
      .fetchWord (memRsp.rdata),
      .rs1Id     (rs1Id),
      .rs2Id     (rs2Id),
      .dec       (dec)
   );

   rvRegFile regFile_i (
      .clk       (clk),
      .readEn    (instrReady),
      .rs1Id     (rs1Id),
      .rs2Id     (rs2Id),
      .rs1       (rs1),
      .rs2       (rs2),
      .writeEn   (writeBack),
      .rdId      (dec.rdId),
      .writeData (writeBackData)
   );

   rvAlu alu_i (
      .clk       (clk),
      .start     (aluStart),
      .ctrl      (dec.aluCtrl),
      .in1       (rs1),
      .in2       (aluIn2),
      .result    (aluResult),
      .predicate (predicate)
   );

   rvLoadStore loadStore_i (
      .funct3    (dec.funct3),
      .addrLow   (lsAddr[1:0]),
      .storeData (rs2),
      .rdata     (memRsp.rdata),
      .loadData  (loadData),
      .wdata     (storeWdata),
      .wmask     (storeMask)
   );

   assign pcPlus4 = pc + addr_t'(4);

   // JAL -> jImm, AUIPC -> uImm, branch -> bImm
   assign pcImm = dec.isJal   ? dec.jImm[addrWidth-1:0] :
                  dec.isAuipc ? dec.uImm[addrWidth-1:0] :
                                dec.bImm[addrWidth-1:0];
   assign lsImm = dec.isStore ? dec.sImm[addrWidth-1:0] : dec.iImm[addrWidth-1:0];

   // Adders settle in execute1, used from execute2 on
   always_ff @(posedge clk) begin
      if (state[execute1Bit]) begin
         pcPlusImm  <= pc + pcImm;
         rs1PlusImm <= rs1[addrWidth-1:0] + dec.iImm[addrWidth-1:0];
         lsAddr     <= rs1[addrWidth-1:0] + lsImm;
      end
   end

   // Repeats in waitMem so a load ends with the settled data
   assign writeBack = !(dec.isBranch | dec.isStore) &
                      (state[execute2Bit] | state[waitMemBit]);

   assign writeBackData =
      (dec.isLui              ? dec.uImm                       : '0) |
      (isAlu                  ? aluResult                      : '0) |
      (dec.isAuipc            ? {{padWidth{1'b0}}, pcPlusImm}  : '0) |
      (dec.isJal | dec.isJalr ? {{padWidth{1'b0}}, pcPlus4}    : '0) |  // Link
      (dec.isLoad             ? loadData                       : '0);

   always_comb begin
      memReq.addr  = {{padWidth{1'b0}}, fetchPhase ? pc : lsAddr};
      memReq.wdata = storeWdata;
      memReq.wmask = {4{state[execute2Bit] & dec.isStore}} & storeMask;
      memReq.rstrb = state[fetchBit] | (state[execute2Bit] & dec.isLoad);
   end

   always_ff @(posedge clk) begin
      if (!reset) begin
         state <= waitMemState;  // Leaves once both busy lines are low
         pc    <= resetAddr;
      end else begin
         case (1'b1)
            state[waitInstrBit]: begin
               if (!memRsp.rbusy) begin  // Decoder and register file latch now
                  state <= execute1State;
               end
            end
            state[execute1Bit]: begin
               state <= execute2State;
            end
            state[execute2Bit]: begin
               if (dec.isJalr) begin
                  pc <= {rs1PlusImm[addrWidth-1:1], 1'b0};  // Target LSB cleared
               end else if (jumpToPcImm) begin
                  pc <= pcPlusImm;
               end else begin
                  pc <= pcPlus4;
               end
               state <= memAccess ? waitMemState : fetchState;
            end
            state[waitMemBit]: begin
               if (!memRsp.rbusy && !memRsp.wbusy) begin
                  state <= fetchState;
               end
            end
            default: begin  // Fetch, rstrb out for one cycle
               state <= waitInstrState;
            end
         endcase
      end
   end

endmodule

`default_nettype wire

//--- hw/rvLoadStore.sv
// Load and store alignment for byte, halfword and word accesses
// Load lane selection with sign or zero extension
// Store lane replication and byte write mask
`default_nettype none

module rvLoadStore (
   input  logic [2:0]   funct3,     // [1:0] size, [2] unsigned load
   input  logic [1:0]   addrLow,
   input  rvPkg::word_t storeData,  // rs2
   input  rvPkg::word_t rdata,
   output rvPkg::word_t loadData,
   output rvPkg::word_t wdata,
   output logic [3:0]   wmask       // Gated to stores by the sequencer
);
   import rvPkg::*;

   logic        byteAccess;
   logic        halfAccess;
   logic [15:0] loadHalf;
   logic [7:0]  loadByte;
   logic        loadSign;

   assign byteAccess = (funct3[1:0] == 2'b00);
   assign halfAccess = (funct3[1:0] == 2'b01);

   // Halfword first, then the byte inside it
   assign loadHalf = addrLow[1] ? rdata[31:16] : rdata[15:0];
   assign loadByte = addrLow[0] ? loadHalf[15:8] : loadHalf[7:0];

   assign loadSign = !funct3[2] & (byteAccess ? loadByte[7] : loadHalf[15]);

   always_comb begin
      if (byteAccess) begin
         loadData = {{24{loadSign}}, loadByte};
      end else if (halfAccess) begin
         loadData = {{16{loadSign}}, loadHalf};
      end else begin
         loadData = rdata;  // LW
      end
   end

   // Low byte/halfword copied into every lane it can land in
   assign wdata[7:0]   = storeData[7:0];
   assign wdata[15:8]  = addrLow[0] ? storeData[7:0] : storeData[15:8];
   assign wdata[23:16] = addrLow[1] ? storeData[7:0] : storeData[23:16];
   assign wdata[31:24] = addrLow[0] ? storeData[7:0] :
                         addrLow[1] ? storeData[15:8] : storeData[31:24];

   always_comb begin
      if (byteAccess) begin
         wmask = 4'b0001 << addrLow;             // One lane
      end else if (halfAccess) begin
         wmask = addrLow[1] ? 4'b1100 : 4'b0011;  // Lane pair
      end else begin
         wmask = 4'b1111;
      end
   end

endmodule

`default_nettype wire

//--- hw/rvAlu.sv
// One-cycle ALU for RV32I register and immediate operations
// One 33-bit subtractor for SUB, SLT, SLTU and all branch tests
// Barrel shifter, right only, with the word reversed for left shifts
// Combinational branch predicate
`default_nettype none

module rvAlu (
   input  logic            clk,
   input  logic            start,      // Registers a new result
   input  rvPkg::aluCtrl_s ctrl,
   input  rvPkg::word_t    in1,
   input  rvPkg::word_t    in2,
   output rvPkg::word_t    result,
   output logic            predicate   // Branch taken
);
   import rvPkg::*;

   word_t             sum;
   logic [xlen:0]     minus;       // Bit 32 is the borrow
   logic              lt;
   logic              ltu;
   logic              eq;
   word_t             shifterIn;
   logic signed [xlen:0] shiftExt;
   logic signed [xlen:0] shiftOut;
   word_t             rightShift;
   word_t             leftShift;

   function automatic word_t flip(input word_t x);
      word_t y;
      for (int k = 0; k < xlen; k++) begin
         y[k] = x[xlen-1-k];
      end
      return y;
   endfunction

   assign sum   = in1 + in2;
   assign minus = {1'b1, ~in2} + {1'b0, in1} + (xlen+1)'(1);  // in1 - in2

   assign lt  = (in1[xlen-1] ^ in2[xlen-1]) ? in1[xlen-1] : minus[xlen];  // Signs differ
   assign ltu = minus[xlen];
   assign eq  = (minus[xlen-1:0] == '0);

   // funct3[2] is set for right shifts
   assign shifterIn  = ctrl.funct3[2] ? in1 : flip(in1);
   assign shiftExt   = {ctrl.arith & in1[xlen-1], shifterIn};  // Sign bit for SRA only
   assign shiftOut   = shiftExt >>> in2[4:0];
   assign rightShift = shiftOut[xlen-1:0];
   assign leftShift  = flip(rightShift);

   always_ff @(posedge clk) begin
      if (start) begin
         case (ctrl.funct3)
            3'b000:  result <= ctrl.sub ? minus[xlen-1:0] : sum;  // ADD/SUB
            3'b001:  result <= leftShift;                         // SLL
            3'b010:  result <= {{(xlen-1){1'b0}}, lt};            // SLT
            3'b011:  result <= {{(xlen-1){1'b0}}, ltu};           // SLTU
            3'b100:  result <= in1 ^ in2;
            3'b101:  result <= rightShift;                        // SRL/SRA
            3'b110:  result <= in1 | in2;
            default: result <= in1 & in2;
         endcase
      end
   end

   always_comb begin
      case (ctrl.funct3)
         3'b000:  predicate = eq;    // BEQ
         3'b001:  predicate = !eq;   // BNE
         3'b100:  predicate = lt;    // BLT
         3'b101:  predicate = !lt;   // BGE
         3'b110:  predicate = ltu;   // BLTU
         3'b111:  predicate = !ltu;  // BGEU
         default: predicate = 1'b0;  // Not a branch encoding
      endcase
   end

endmodule

`default_nettype wire

//--- hw/rvRegFile.sv
// Register file, 32 x 32 bits
// Dual registered read during instruction fetch, single write port
`default_nettype none

module rvRegFile (
   input  logic         clk,
   input  logic         readEn,     // Same cycle the decoder latches
   input  logic [4:0]   rs1Id,
   input  logic [4:0]   rs2Id,
   output rvPkg::word_t rs1,
   output rvPkg::word_t rs2,
   input  logic         writeEn,
   input  logic [4:0]   rdId,
   input  rvPkg::word_t writeData
);
   import rvPkg::*;

   word_t regs [regCount];

   // x0 is never stored, so its read is forced to zero
   always_ff @(posedge clk) begin
      if (readEn) begin
         rs1 <= (rs1Id == 5'd0) ? '0 : regs[rs1Id];
         rs2 <= (rs2Id == 5'd0) ? '0 : regs[rs2Id];
      end
   end

   always_ff @(posedge clk) begin
      if (writeEn && rdId != 5'd0) begin
         regs[rdId] <= writeData;
      end
   end

endmodule

`default_nettype wire

//--- hw/rvDecoder.sv
// Instruction latch and decoder
// Register ids taken straight from the fetched word for the register read
// Opcode classes, sign-extended immediates and ALU control from the latched word
`default_nettype none

module rvDecoder (
   input  logic            clk,
   input  logic            load,       // High in the cycle rdata holds the instruction
   input  rvPkg::word_t    fetchWord,
   output logic [4:0]      rs1Id,
   output logic [4:0]      rs2Id,
   output rvPkg::decoded_s dec
);
   import rvPkg::*;

   instr_u     instr;      // Latched instruction
   instr_u     fetchView;  // Word on the bus, read before it is latched
   logic [4:0] opClass;

   assign fetchView = fetchWord;
   assign rs1Id     = fetchView.r.rs1;
   assign rs2Id     = fetchView.r.rs2;

   always_ff @(posedge clk) begin
      if (load) begin
         instr <= fetchWord;
      end
   end

   assign opClass = instr.r.opcode[6:2];  // Bits 1:0 are 2'b11 for all RV32I

   always_comb begin
      dec.isLoad   = (opClass == opLoad);    // rd <- mem[rs1+iImm]
      dec.isAluImm = (opClass == opAluImm);  // rd <- rs1 op iImm
      dec.isAuipc  = (opClass == opAuipc);   // rd <- PC+uImm
      dec.isStore  = (opClass == opStore);   // mem[rs1+sImm] <- rs2
      dec.isAluReg = (opClass == opAluReg);  // rd <- rs1 op rs2
      dec.isLui    = (opClass == opLui);     // rd <- uImm
      dec.isBranch = (opClass == opBranch);
      dec.isJal    = (opClass == opJal);
      dec.isJalr   = (opClass == opJalr);

      dec.rdId   = instr.r.rd;
      dec.funct3 = instr.r.funct3;

      // Immediates, one per format view
      dec.iImm = {{20{instr.i.imm[11]}}, instr.i.imm};
      dec.sImm = {{20{instr.s.immHi[6]}}, instr.s.immHi, instr.s.immLo};
      dec.bImm = {{19{instr.b.imm12}}, instr.b.imm12, instr.b.imm11,
                  instr.b.imm10_5, instr.b.imm4_1, 1'b0};
      dec.uImm = {instr.u.imm, 12'b0};
      dec.jImm = {{11{instr.j.imm20}}, instr.j.imm20, instr.j.imm19_12,
                  instr.j.imm11, instr.j.imm10_1, 1'b0};

      dec.aluCtrl.funct3 = instr.r.funct3;
      // ADDI shares bit 30 with the immediate, so SUB needs the register form
      dec.aluCtrl.sub    = dec.isAluReg & instr.r.funct7[5];
      dec.aluCtrl.arith  = instr.r.funct7[5];   // Same bit for SRA and SRAI
      dec.aluCtrl.useImm = dec.isAluImm;
   end

endmodule

`default_nettype wire

//--- hw/rvPkg.sv
// Shared definitions for the femtoCore RV32I core
// Data and address widths, reset address, opcode classes
// One-hot sequencer bit positions and state codes
// Instruction format views, ALU control, decoded instruction, memory bus
`default_nettype none

package rvPkg;

   localparam int xlen      = 32;
   localparam int addrWidth = 24;                // Internal address width
   localparam int padWidth  = xlen - addrWidth;  // Zero bits above an address on the bus
   localparam int regCount  = 32;

   typedef logic [xlen-1:0]      word_t;
   typedef logic [addrWidth-1:0] addr_t;

   localparam addr_t resetAddr = '0;  // First fetch

   // Opcode classes, instr[6:2]
   localparam logic [4:0] opLoad   = 5'b00000;
   localparam logic [4:0] opAluImm = 5'b00100;
   localparam logic [4:0] opAuipc  = 5'b00101;
   localparam logic [4:0] opStore  = 5'b01000;
   localparam logic [4:0] opAluReg = 5'b01100;
   localparam logic [4:0] opLui    = 5'b01101;
   localparam logic [4:0] opBranch = 5'b11000;
   localparam logic [4:0] opJalr   = 5'b11001;
   localparam logic [4:0] opJal    = 5'b11011;

   // Sequencer, one bit per state
   localparam int fetchBit     = 0;
   localparam int waitInstrBit = 1;
   localparam int execute1Bit  = 2;
   localparam int execute2Bit  = 3;
   localparam int waitMemBit   = 4;
   localparam int stateCount   = 5;

   localparam logic [stateCount-1:0] fetchState     = stateCount'(1) << fetchBit;
   localparam logic [stateCount-1:0] waitInstrState = stateCount'(1) << waitInstrBit;
   localparam logic [stateCount-1:0] execute1State  = stateCount'(1) << execute1Bit;
   localparam logic [stateCount-1:0] execute2State  = stateCount'(1) << execute2Bit;
   localparam logic [stateCount-1:0] waitMemState   = stateCount'(1) << waitMemBit;

   // Instruction formats, MSB first
   typedef struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
   } rFmt_s;

   typedef struct packed {
      logic [11:0] imm;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
   } iFmt_s;

   typedef struct packed {
      logic [6:0] immHi;   // imm[11:5]
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] immLo;   // imm[4:0]
      logic [6:0] opcode;
   } sFmt_s;

   typedef struct packed {
      logic       imm12;
      logic [5:0] imm10_5;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [3:0] imm4_1;
      logic       imm11;
      logic [6:0] opcode;
   } bFmt_s;

   typedef struct packed {
      logic [19:0] imm;    // imm[31:12]
      logic [4:0]  rd;
      logic [6:0]  opcode;
   } uFmt_s;

   typedef struct packed {
      logic       imm20;
      logic [9:0] imm10_1;
      logic       imm11;
      logic [7:0] imm19_12;
      logic [4:0] rd;
      logic [6:0] opcode;
   } jFmt_s;

   typedef union packed {
      rFmt_s r;
      iFmt_s i;
      sFmt_s s;
      bFmt_s b;
      uFmt_s u;
      jFmt_s j;
   } instr_u;

   typedef struct packed {
      logic [2:0] funct3;
      logic       sub;     // SUB, register form only
      logic       arith;   // SRA/SRAI
      logic       useImm;  // Second operand is iImm
   } aluCtrl_s;

   typedef struct packed {
      logic     isLoad;
      logic     isAluImm;
      logic     isAluReg;
      logic     isAuipc;
      logic     isStore;
      logic     isLui;
      logic     isBranch;
      logic     isJal;
      logic     isJalr;
      logic [4:0] rdId;
      logic [2:0] funct3;
      word_t    iImm;
      word_t    sImm;
      word_t    bImm;
      word_t    uImm;
      word_t    jImm;
      aluCtrl_s aluCtrl;
   } decoded_s;

   typedef struct packed {
      word_t      addr;
      word_t      wdata;
      logic [3:0] wmask;   // Nonzero for one cycle per store
      logic       rstrb;   // One cycle per read
   } memReq_s;

   typedef struct packed {
      word_t rdata;
      logic  rbusy;
      logic  wbusy;
   } memRsp_s;

endpackage

`default_nettype wire
